//--- logic/rv32i_isa_pkg.sv
`default_nettype none

package rv32i_isa_pkg;

    localparam int XLEN     = 32;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;

    // Field positions in the instruction word
    localparam int OPCODE_LSB = 0;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT7_LSB = 25;

    // funct7 value for SUB and the arithmetic right shifts
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT = 7'b0100000;

    typedef enum logic [OPCODE_W-1:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_OP_IMM = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [FUNCT3_W-1:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } funct3_branch_e;

    typedef enum logic [FUNCT3_W-1:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_alu_e;

endpackage

`default_nettype wire

//--- logic/datapath_ctl_pkg.sv
`default_nettype none

package datapath_ctl_pkg;

    localparam int ALU_OP_W  = 4;
    localparam int IMM_SEL_W = 4;
    localparam int WB_SEL_W  = 2;

    // Codes as seen by the ALU with unused gaps
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_XOR    = 4'b0010,
        ALU_ADD    = 4'b0011,
        ALU_SUB    = 4'b0100,
        ALU_PASS_B = 4'b0110,
        ALU_SLL    = 4'b0111,
        ALU_SRL    = 4'b1000,
        ALU_SRA    = 4'b1010,
        ALU_SLTU   = 4'b1011,
        ALU_SLT    = 4'b1100
    } alu_op_e;

    // Immediate generator format
    typedef enum logic [IMM_SEL_W-1:0] {
        IMM_R = 4'd0,
        IMM_I = 4'd1,
        IMM_S = 4'd2,
        IMM_B = 4'd3,
        IMM_U = 4'd4,
        IMM_J = 4'd5
    } imm_sel_e;

    typedef enum logic {
        A_RS1 = 1'b0,
        A_PC  = 1'b1
    } a_sel_e;

    typedef enum logic {
        B_RS2 = 1'b0,
        B_IMM = 1'b1
    } b_sel_e;

    typedef enum logic [WB_SEL_W-1:0] {
        WB_MEM = 2'd0,
        WB_ALU = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

endpackage

`default_nettype wire

//--- logic/opcode_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module opcode_decoder (
    input  wire rv32i_isa_pkg::opcode_e      opcode,
    output datapath_ctl_pkg::a_sel_e         a_sel,
    output datapath_ctl_pkg::b_sel_e         b_sel,
    output datapath_ctl_pkg::imm_sel_e       imm_sel,
    output logic                             mem_wr,
    output logic                             reg_wen,
    output datapath_ctl_pkg::wb_sel_e        wb_sel
);

    import rv32i_isa_pkg::*;
    import datapath_ctl_pkg::*;

    always_comb begin
        // Inactive unless the opcode says otherwise
        a_sel   = A_RS1;
        b_sel   = B_RS2;
        imm_sel = IMM_R;
        mem_wr  = 1'b0;
        reg_wen = 1'b0;
        wb_sel  = WB_MEM;
        case (opcode)
            OP_LUI: begin
                b_sel   = B_IMM;
                imm_sel = IMM_U;
                reg_wen = 1'b1;
                wb_sel  = WB_ALU;
            end
            OP_AUIPC: begin
                a_sel   = A_PC;
                b_sel   = B_IMM;
                imm_sel = IMM_U;
                reg_wen = 1'b1;
                wb_sel  = WB_ALU;
            end
            OP_JAL: begin
                a_sel   = A_PC;
                b_sel   = B_IMM;
                imm_sel = IMM_J;
                reg_wen = 1'b1;
                wb_sel  = WB_PC4;
            end
            OP_JALR: begin
                b_sel   = B_IMM;
                imm_sel = IMM_I;
                reg_wen = 1'b1;
                wb_sel  = WB_PC4;
            end
            OP_BRANCH: begin
                imm_sel = IMM_B;
            end
            OP_LOAD: begin
                b_sel   = B_IMM;
                imm_sel = IMM_I;
                reg_wen = 1'b1;
                wb_sel  = WB_MEM;
            end
            OP_STORE: begin
                b_sel   = B_IMM;
                imm_sel = IMM_S;
                mem_wr  = 1'b1;
            end
            OP_OP_IMM: begin
                b_sel   = B_IMM;
                imm_sel = IMM_I;
                reg_wen = 1'b1;
                wb_sel  = WB_ALU;
            end
            OP_OP: begin
                reg_wen = 1'b1;
                wb_sel  = WB_ALU;
            end
            default: begin
                reg_wen = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/alu_op_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module alu_op_decoder (
    input  wire rv32i_isa_pkg::opcode_e opcode,
    input  wire [2:0]                   funct3,
    input  wire [6:0]                   funct7,
    output datapath_ctl_pkg::alu_op_e   alu_op
);

    import rv32i_isa_pkg::*;
    import datapath_ctl_pkg::*;

    logic alt;

    assign alt = (funct7 == FUNCT7_ALT);

    always_comb begin
        alu_op = ALU_AND;
        case (opcode)
            OP_LUI: begin
                alu_op = ALU_PASS_B;
            end
            // Address and target arithmetic
            OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE: begin
                alu_op = ALU_ADD;
            end
            OP_OP, OP_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: begin
                        // ADDI has no subtract form
                        if (opcode == OP_OP && alt) begin
                            alu_op = ALU_SUB;
                        end else begin
                            alu_op = ALU_ADD;
                        end
                    end
                    F3_SLL: begin
                        alu_op = ALU_SLL;
                    end
                    F3_SLT: begin
                        alu_op = ALU_SLT;
                    end
                    F3_SLTU: begin
                        alu_op = ALU_SLTU;
                    end
                    F3_XOR: begin
                        alu_op = ALU_XOR;
                    end
                    F3_SR: begin
                        alu_op = alt ? ALU_SRA : ALU_SRL;
                    end
                    F3_OR: begin
                        alu_op = ALU_OR;
                    end
                    F3_AND: begin
                        alu_op = ALU_AND;
                    end
                    default: begin
                        alu_op = ALU_AND;
                    end
                endcase
            end
            default: begin
                alu_op = ALU_AND;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/branch_resolver.sv
`timescale 1ns/1ns
`default_nettype none

module branch_resolver (
    input  wire rv32i_isa_pkg::opcode_e opcode,
    input  wire [2:0]                   funct3,
    input  wire                         br_eq,
    input  wire                         br_lt,
    output logic                        pc_sel,
    output logic                        br_un
);

    import rv32i_isa_pkg::*;

    always_comb begin
        pc_sel = 1'b0;
        br_un  = 1'b0;
        case (opcode)
            OP_JAL, OP_JALR: begin
                pc_sel = 1'b1;
            end
            OP_BRANCH: begin
                case (funct3)
                    BEQ:  pc_sel = br_eq;
                    BNE:  pc_sel = !br_eq;
                    BLT:  pc_sel = br_lt;
                    BGE:  pc_sel = !br_lt;
                    // Comparator runs unsigned for these two
                    BLTU: begin
                        br_un  = 1'b1;
                        pc_sel = br_lt;
                    end
                    BGEU: begin
                        br_un  = 1'b1;
                        pc_sel = !br_lt;
                    end
                    default: pc_sel = 1'b0;
                endcase
            end
            default: begin
                pc_sel = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ctl_stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module ctl_stage_reg (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               in_valid,
    output logic                              in_ready,
    input  wire datapath_ctl_pkg::a_sel_e     next_a_sel,
    input  wire datapath_ctl_pkg::b_sel_e     next_b_sel,
    input  wire datapath_ctl_pkg::alu_op_e    next_alu_sel,
    input  wire datapath_ctl_pkg::imm_sel_e   next_imm_sel,
    input  wire                               next_mem_wr,
    input  wire                               next_reg_wen,
    input  wire                               next_br_un,
    input  wire                               next_pc_sel,
    input  wire datapath_ctl_pkg::wb_sel_e    next_wb_sel,
    output logic                              out_valid,
    input  wire                               out_ready,
    output datapath_ctl_pkg::a_sel_e          a_sel,
    output datapath_ctl_pkg::b_sel_e          b_sel,
    output datapath_ctl_pkg::alu_op_e         alu_sel,
    output datapath_ctl_pkg::imm_sel_e        imm_sel,
    output logic                              mem_wr,
    output logic                              reg_wen,
    output logic                              br_un,
    output logic                              pc_sel,
    output datapath_ctl_pkg::wb_sel_e         wb_sel
);

    import datapath_ctl_pkg::*;

    logic load;

    // Accept when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            a_sel     <= A_RS1;
            b_sel     <= B_RS2;
            alu_sel   <= ALU_AND;
            imm_sel   <= IMM_R;
            mem_wr    <= 1'b0;
            reg_wen   <= 1'b0;
            br_un     <= 1'b0;
            pc_sel    <= 1'b0;
            wb_sel    <= WB_MEM;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid;
            end
            if (load) begin
                a_sel   <= next_a_sel;
                b_sel   <= next_b_sel;
                alu_sel <= next_alu_sel;
                imm_sel <= next_imm_sel;
                mem_wr  <= next_mem_wr;
                reg_wen <= next_reg_wen;
                br_un   <= next_br_un;
                pc_sel  <= next_pc_sel;
                wb_sel  <= next_wb_sel;
            end
        end
    end

    logic [15:0] ctl_bus;

    assign ctl_bus = {a_sel, b_sel, alu_sel, imm_sel, mem_wr, reg_wen, br_un, pc_sel, wb_sel};

    a_ctl_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(ctl_bus));

    // Held item must not move while stalled
    a_ctl_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(ctl_bus));

    a_no_mem_and_reg_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_wr && reg_wen));

endmodule

`default_nettype wire

//--- logic/instr_ctl.sv
`timescale 1ns/1ns
`default_nettype none

module instr_ctl (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire [rv32i_isa_pkg::XLEN-1:0]       instruction,
    input  wire                                 in_valid,
    output logic                                in_ready,
    input  wire                                 br_eq,
    input  wire                                 br_lt,
    output logic                                out_valid,
    input  wire                                 out_ready,
    output datapath_ctl_pkg::a_sel_e            a_sel,
    output datapath_ctl_pkg::b_sel_e            b_sel,
    output datapath_ctl_pkg::alu_op_e           alu_sel,
    output datapath_ctl_pkg::imm_sel_e          imm_sel,
    output logic                                mem_wr,
    output logic                                reg_wen,
    output logic                                br_un,
    output logic                                pc_sel,
    output datapath_ctl_pkg::wb_sel_e           wb_sel
);

    rv32i_isa_pkg::opcode_e                 opcode;
    logic [rv32i_isa_pkg::FUNCT3_W-1:0]     funct3;
    logic [rv32i_isa_pkg::FUNCT7_W-1:0]     funct7;

    datapath_ctl_pkg::a_sel_e               next_a_sel;
    datapath_ctl_pkg::b_sel_e               next_b_sel;
    datapath_ctl_pkg::alu_op_e              next_alu_sel;
    datapath_ctl_pkg::imm_sel_e             next_imm_sel;
    datapath_ctl_pkg::wb_sel_e              next_wb_sel;
    logic                                   next_mem_wr;
    logic                                   next_reg_wen;
    logic                                   next_br_un;
    logic                                   next_pc_sel;

    // Undefined opcodes keep their raw value and fall to the decoder defaults
    assign opcode = rv32i_isa_pkg::opcode_e'(
        instruction[rv32i_isa_pkg::OPCODE_LSB +: rv32i_isa_pkg::OPCODE_W]);
    assign funct3 = instruction[rv32i_isa_pkg::FUNCT3_LSB +: rv32i_isa_pkg::FUNCT3_W];
    assign funct7 = instruction[rv32i_isa_pkg::FUNCT7_LSB +: rv32i_isa_pkg::FUNCT7_W];

    opcode_decoder u_opcode_decoder (
        .opcode  (opcode),
        .a_sel   (next_a_sel),
        .b_sel   (next_b_sel),
        .imm_sel (next_imm_sel),
        .mem_wr  (next_mem_wr),
        .reg_wen (next_reg_wen),
        .wb_sel  (next_wb_sel)
    );

    alu_op_decoder u_alu_op_decoder (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .alu_op (next_alu_sel)
    );

    branch_resolver u_branch_resolver (
        .opcode (opcode),
        .funct3 (funct3),
        .br_eq  (br_eq),
        .br_lt  (br_lt),
        .pc_sel (next_pc_sel),
        .br_un  (next_br_un)
    );

    ctl_stage_reg u_ctl_stage_reg (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .next_a_sel   (next_a_sel),
        .next_b_sel   (next_b_sel),
        .next_alu_sel (next_alu_sel),
        .next_imm_sel (next_imm_sel),
        .next_mem_wr  (next_mem_wr),
        .next_reg_wen (next_reg_wen),
        .next_br_un   (next_br_un),
        .next_pc_sel  (next_pc_sel),
        .next_wb_sel  (next_wb_sel),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .a_sel        (a_sel),
        .b_sel        (b_sel),
        .alu_sel      (alu_sel),
        .imm_sel      (imm_sel),
        .mem_wr       (mem_wr),
        .reg_wen      (reg_wen),
        .br_un        (br_un),
        .pc_sel       (pc_sel),
        .wb_sel       (wb_sel)
    );

endmodule

`default_nettype wire

//--- verif/ctl_model.svh
`ifndef CTL_MODEL_SVH
`define CTL_MODEL_SVH

// Expected controls packed as {a, b, alu, imm, mem_wr, reg_wen, br_un, pc_sel, wb}
function automatic logic [15:0] ctl_model(input logic [31:0] ins, input logic eq, input logic lt);
    opcode_e    op;
    logic [2:0] f3;
    logic       alt;
    a_sel_e     a;
    b_sel_e     b;
    alu_op_e    alu;
    imm_sel_e   imm;
    wb_sel_e    wb;
    logic       mw;
    logic       rw;
    logic       un;
    logic       pc;
    logic       cond;
    op   = opcode_e'(ins[OPCODE_LSB +: 7]);
    f3   = ins[FUNCT3_LSB +: 3];
    alt  = (ins[FUNCT7_LSB +: 7] == FUNCT7_ALT);
    a    = A_RS1;
    b    = B_RS2;
    alu  = ALU_AND;
    imm  = IMM_R;
    wb   = WB_MEM;
    mw   = 1'b0;
    rw   = 1'b0;
    un   = 1'b0;
    pc   = 1'b0;
    cond = 1'b0;

    // Everything that reads an immediate takes it on operand B, except branches
    if (op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_STORE, OP_OP_IMM}) begin
        b = B_IMM;
    end
    if (op == OP_AUIPC || op == OP_JAL) begin
        a = A_PC;
    end
    if (op == OP_LUI || op == OP_AUIPC) begin
        imm = IMM_U;
    end else if (op == OP_JAL) begin
        imm = IMM_J;
    end else if (op == OP_JALR || op == OP_LOAD || op == OP_OP_IMM) begin
        imm = IMM_I;
    end else if (op == OP_STORE) begin
        imm = IMM_S;
    end else if (op == OP_BRANCH) begin
        imm = IMM_B;
    end
    rw = op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_OP_IMM, OP_OP};
    mw = (op == OP_STORE);
    if (op == OP_JAL || op == OP_JALR) begin
        wb = WB_PC4;
        pc = 1'b1;
    end else if (op inside {OP_LUI, OP_AUIPC, OP_OP_IMM, OP_OP}) begin
        wb = WB_ALU;
    end

    if (op == OP_LUI) begin
        alu = ALU_PASS_B;
    end else if (op inside {OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE}) begin
        alu = ALU_ADD;
    end else if (op == OP_OP || op == OP_OP_IMM) begin
        case (f3)
            F3_ADD_SUB: alu = (op == OP_OP && alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu = ALU_SLL;
            F3_SLT:     alu = ALU_SLT;
            F3_SLTU:    alu = ALU_SLTU;
            F3_XOR:     alu = ALU_XOR;
            F3_SR:      alu = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu = ALU_OR;
            default:    alu = ALU_AND;
        endcase
    end

    // funct3 bit 2 picks the less-than flag, bit 0 inverts, bits 2:1 both set is unsigned
    if (op == OP_BRANCH && f3[2:1] != 2'b01) begin
        cond = f3[2] ? lt : eq;
        pc   = cond ^ f3[0];
        un   = f3[2] & f3[1];
    end
    return {a, b, alu, imm, mw, rw, un, pc, wb};
endfunction

`endif

//--- verif/tb_instr_ctl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_instr_ctl;

    import rv32i_isa_pkg::*;
    import datapath_ctl_pkg::*;

    `include "ctl_model.svh"

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int HS_LIMIT     = 20;
    localparam int BP_ITEMS     = 40;
    localparam int N_TXN        = 32 + 24 + 48 + BP_ITEMS + 18;
    localparam int WATCHDOG_NS  = (N_TXN * 10 + RESET_CYCLES) * CLK_PERIOD;
    localparam logic [6:0] FENCE_OP  = 7'b0001111;
    localparam logic [6:0] SYSTEM_OP = 7'b1110011;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] instruction;
    logic        in_valid;
    logic        in_ready;
    logic        br_eq;
    logic        br_lt;
    logic        out_valid;
    logic        out_ready;
    logic        a_sel;
    logic        b_sel;
    logic [3:0]  alu_sel;
    logic [3:0]  imm_sel;
    logic        mem_wr;
    logic        reg_wen;
    logic        br_un;
    logic        pc_sel;
    logic [1:0]  wb_sel;
    logic [15:0] dut_ctl;

    logic [15:0]  exp_ctl;
    logic [31:0]  rand_word;
    logic [127:0] stall_bits;
    logic [6:0]   cur_op;
    logic [6:0]   cur_f7;
    logic         bp_done;
    integer       seed;
    string        test_name = "reset";
    int take_count = 0;
    int take_base;
    int err_base;
    int sent;
    int stretch;
    int check_errors = 0;
    int flow_errors = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    instr_ctl UUT (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .alu_sel     (alu_sel),
        .imm_sel     (imm_sel),
        .mem_wr      (mem_wr),
        .reg_wen     (reg_wen),
        .br_un       (br_un),
        .pc_sel      (pc_sel),
        .wb_sel      (wb_sel)
    );

    assign dut_ctl = {a_sel, b_sel, alu_sel, imm_sel, mem_wr, reg_wen, br_un, pc_sel, wb_sel};

    // Scoreboard loaded when an instruction is accepted
    always @(posedge clk) begin
        if (rst) begin
            exp_ctl <= '0;
        end else begin
            if (in_valid && in_ready) begin
                exp_ctl <= ctl_model(instruction, br_eq, br_lt);
            end
            if (out_valid && out_ready) begin
                take_count <= take_count + 1;
            end
        end
    end

    ctl_matches_model: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> dut_ctl == exp_ctl)
        else begin
            check_errors++;
            $display("Error %s: expected %h actual %h", test_name,
                $sampled(exp_ctl), $sampled(dut_ctl));
        end

    latency_one_cycle: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready |=> out_valid)
        else begin
            check_errors++;
            $display("Error %s: expected out_valid 1 actual 0", test_name);
        end

    held_while_stalled: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else begin
            check_errors++;
            $display("%s: out_valid dropped before the output was taken", test_name);
        end

    taken_once: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && !in_valid |=> !out_valid)
        else begin
            check_errors++;
            $display("%s: an item was presented again after it was taken", test_name);
        end

    function automatic logic [31:0] make_instr(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [6:0] op7);
        logic [31:0] word;
        word = $random(seed);
        word[FUNCT7_LSB +: 7] = f7;
        word[FUNCT3_LSB +: 3] = f3;
        word[OPCODE_LSB +: 7] = op7;
        return word;
    endfunction

    function automatic logic [6:0] pick_defined_op(input logic [3:0] sel);
        case (sel)
            4'd0:    return OP_LUI;
            4'd1:    return OP_AUIPC;
            4'd2:    return OP_JAL;
            4'd3:    return OP_JALR;
            4'd4:    return OP_BRANCH;
            4'd5:    return OP_LOAD;
            4'd6:    return OP_STORE;
            4'd7:    return OP_OP_IMM;
            default: return OP_OP;
        endcase
    endfunction

    function automatic logic is_defined_opcode(input logic [6:0] op7);
        return op7 inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
                           OP_LOAD, OP_STORE, OP_OP_IMM, OP_OP};
    endfunction

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_instr(input logic [31:0] ins, input logic eq, input logic lt);
        int waited;
        begin
            waited      = 0;
            instruction = ins;
            br_eq       = eq;
            br_lt       = lt;
            in_valid    = 1'b1;
            @(negedge clk);
            while (!in_ready && waited < HS_LIMIT) begin
                waited++;
                @(negedge clk);
            end
            if (!in_ready) begin
                flow_errors++;
                $display("%s: instruction %h was never accepted", test_name, ins);
            end else begin
                sent++;
            end
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic drain_output;
        int waited;
        begin
            waited    = 0;
            in_valid  = 1'b0;
            out_ready = 1'b1;
            @(negedge clk);
            while (out_valid && waited < HS_LIMIT) begin
                waited++;
                @(negedge clk);
            end
            if (out_valid) begin
                flow_errors++;
                $display("%s: the last output was never taken", test_name);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        sent      = 0;
        take_base = take_count;
        err_base  = check_errors + flow_errors;
    endtask

    task automatic end_test;
        int errs;
        begin
            drain_output();
            assert (take_count - take_base == sent)
            else begin
                flow_errors++;
                $display("Error %s: expected %0d taken, actual %0d",
                    test_name, sent, take_count - take_base);
            end
            errs = check_errors + flow_errors - err_base;
            if (errs == 0) begin
                tests_ok++;
            end else begin
                tests_bad++;
            end
            $display("%s: %0d instructions, %0d errors", test_name, sent, errs);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed        = 32'h9160_407a;
        rst         = 1'b1;
        instruction = '0;
        in_valid    = 1'b0;
        br_eq       = 1'b0;
        br_lt       = 1'b0;
        out_ready   = 1'b1;
        bp_done     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("reset");
        @(negedge clk);
        assert (!out_valid && dut_ctl == 16'h0)
        else begin
            flow_errors++;
            $display("Error %s: expected %h actual %h", test_name, 17'h0, {out_valid, dut_ctl});
        end
        assert (in_ready)
        else begin
            flow_errors++;
            $display("%s: in_ready is low after reset", test_name);
        end
        @(posedge clk);
        #1;
        end_test();

        begin_test("alu_decode");
        for (int m = 0; m < 2; m++) begin
            for (int k = 0; k < 8; k++) begin
                for (int v = 0; v < 2; v++) begin
                    rand_word = $random(seed);
                    cur_op = (m == 0) ? OP_OP : OP_OP_IMM;
                    cur_f7 = (v == 0) ? 7'b0 : FUNCT7_ALT;
                    send_instr(make_instr(cur_f7, k[2:0], cur_op), rand_word[0], rand_word[1]);
                end
            end
        end
        end_test();

        begin_test("mem_jump_decode");
        for (int rep = 0; rep < 4; rep++) begin
            for (int k = 0; k < 6; k++) begin
                rand_word = $random(seed);
                case (k)
                    0:       cur_op = OP_LOAD;
                    1:       cur_op = OP_STORE;
                    2:       cur_op = OP_LUI;
                    3:       cur_op = OP_AUIPC;
                    4:       cur_op = OP_JAL;
                    default: cur_op = OP_JALR;
                endcase
                send_instr(make_instr(rand_word[31:25], rand_word[14:12], cur_op),
                    rand_word[0], rand_word[1]);
            end
        end
        end_test();

        begin_test("branch_resolve");
        for (int k = 0; k < 8; k++) begin
            // 010 and 011 are not branch conditions
            if (k != 2 && k != 3) begin
                for (int rep = 0; rep < 8; rep++) begin
                    rand_word = $random(seed);
                    send_instr(make_instr(rand_word[31:25], k[2:0], OP_BRANCH),
                        rand_word[0], rand_word[1]);
                end
            end
        end
        end_test();

        begin_test("back_pressure");
        for (int j = 0; j < 4; j++) begin
            stall_bits[32 * j +: 32] = $random(seed);
        end
        bp_done = 1'b0;
        stretch = 0;
        fork
            begin
                for (int n = 0; n < BP_ITEMS; n++) begin
                    rand_word = $random(seed);
                    cur_op = pick_defined_op(rand_word[3:0]);
                    cur_f7 = rand_word[4] ? FUNCT7_ALT : 7'b0;
                    send_instr(make_instr(cur_f7, rand_word[7:5], cur_op),
                        rand_word[8], rand_word[9]);
                end
                bp_done = 1'b1;
            end
            begin
                // Low for 0 to 7 cycles, then high for one
                while (!bp_done) begin
                    out_ready = 1'b0;
                    repeat (stall_bits[3 * (stretch % 40) +: 3]) begin
                        @(posedge clk);
                        #1;
                    end
                    out_ready = 1'b1;
                    stretch++;
                    @(negedge clk);
                    if (!bp_done) begin
                        @(posedge clk);
                        #1;
                    end
                end
            end
        join
        @(posedge clk);
        #1;
        end_test();

        begin_test("unsupported_opcode");
        rand_word = $random(seed);
        send_instr(make_instr(rand_word[31:25], rand_word[14:12], FENCE_OP),
            rand_word[0], rand_word[1]);
        send_instr(make_instr(rand_word[24:18], rand_word[11:9], SYSTEM_OP),
            rand_word[2], rand_word[3]);
        for (int n = 0; n < 16; n++) begin
            rand_word = $random(seed);
            cur_op = rand_word[6:0];
            // Every defined opcode ends in 11
            if (is_defined_opcode(cur_op)) begin
                cur_op[0] = 1'b0;
            end
            send_instr(make_instr(rand_word[31:25], rand_word[14:12], cur_op),
                rand_word[7], rand_word[8]);
        end
        end_test();

        $display("Summary: %0d tests clean, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && check_errors + flow_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+verif
logic/rv32i_isa_pkg.sv
logic/datapath_ctl_pkg.sv
logic/opcode_decoder.sv
logic/alu_op_decoder.sv
logic/branch_resolver.sv
logic/ctl_stage_reg.sv
logic/instr_ctl.sv
verif/tb_instr_ctl.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the instr_ctl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -f src.f \
    --top-module tb_instr_ctl -o sim_instr_ctl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_instr_ctl)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
